// ==== flist.f ====
hdl/sdram_pkg.sv
hdl/sdram_init_seq.sv
hdl/sdram_slot_seq.sv
hdl/sdram_cmd_gen.sv
hdl/sdram_datapath.sv
hdl/sdram_ctrl_top.sv
verification/tb_clk_gen.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv

// ==== hdl/sdram_cmd_gen.sv ====
/*
 * SDRAM command generator
 *   Init commands per step, mode word on the address lines
 *   Slot commands: activate then read or write, or refresh
 *   Registered command, bank/address word and DQ masks
 */

module sdram_cmd_gen (
	input  logic                             mem_clk,
	input  logic                             clk21m,
	input  sdram_pkg::init_step_t            init_step,
	input  logic                             timer_zero,
	input  sdram_pkg::slot_state_t           slot_state,
	input  logic                             slot_run,
	input  logic                             do_refresh,
	input  logic                             req_valid,
	input  logic                             req_write,
	input  logic [sdram_pkg::CPU_ADDR_W-1:0] req_addr,
	output sdram_pkg::sdr_cmd_t              cmd,
	output sdram_pkg::sdr_addr_u             sdr_addr,
	output logic                             dqm_upper,
	output logic                             dqm_lower
);
	import sdram_pkg::*;

	sdr_cmd_t  cmd_nxt;
	sdr_addr_u addr_nxt;
	logic      dqm_upper_nxt;
	logic      dqm_lower_nxt;

	// ----------------------------------------------------------------------
	// Next command
	// ----------------------------------------------------------------------
	always_comb begin
		cmd_nxt       = CMD_NOP;
		addr_nxt      = sdr_addr;
		dqm_upper_nxt = 1'b1;
		dqm_lower_nxt = 1'b1;

		if (init_step != INIT_READY) begin
			if (timer_zero) begin
				case (init_step)
					INIT_FIRST_WAIT: begin
						cmd_nxt = CMD_PRECHARGE_ALL;
						addr_nxt = '0;
						addr_nxt.access.line.cmd.auto_pre = 1'b1;    // All banks
					end
					INIT_PRECHARGE, INIT_REFRESH1: begin
						cmd_nxt = CMD_REFRESH;
					end
					INIT_REFRESH2: begin
						cmd_nxt  = CMD_MODE_SET;
						addr_nxt = MODE_WORD;
					end
					default: begin
						cmd_nxt = CMD_NOP;
					end
				endcase
			end
			else if (init_step == INIT_FIRST_WAIT) begin
				cmd_nxt = CMD_DESELECT;    // Power-up wait
			end
		end
		else if (slot_run) begin
			case (slot_state)
				SLOT_ACTIVATE: begin
					if (do_refresh) begin
						cmd_nxt = CMD_REFRESH;
					end
					else if (req_valid) begin
						cmd_nxt = CMD_ACTIVATE;
						addr_nxt.access.bank     = req_addr[BANK_LSB +: BANK_W];
						addr_nxt.access.line.row = req_addr[ROW_LSB +: ROW_W];
					end
				end
				SLOT_READ_OR_WRITE: begin
					// Only a CPU slot carries a request here
					if (req_valid) begin
						addr_nxt.access.bank              = req_addr[BANK_LSB +: BANK_W];
						addr_nxt.access.line.cmd          = '0;
						addr_nxt.access.line.cmd.auto_pre = 1'b1;
						addr_nxt.access.line.cmd.col      = req_addr[COL_LSB +: COL_W];
						if (req_write) begin
							cmd_nxt       = CMD_WRITE;
							dqm_upper_nxt = ~req_addr[0];    // Odd byte on upper lane
							dqm_lower_nxt =  req_addr[0];
						end
						else begin
							cmd_nxt       = CMD_READ;
							dqm_upper_nxt = 1'b0;
							dqm_lower_nxt = 1'b0;
						end
					end
				end
				default: begin
					cmd_nxt = CMD_NOP;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Pin registers
	// ----------------------------------------------------------------------
	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			cmd       <= CMD_DESELECT;
			dqm_upper <= 1'b1;
			dqm_lower <= 1'b1;
		end
		else begin
			cmd       <= cmd_nxt;
			dqm_upper <= dqm_upper_nxt;
			dqm_lower <= dqm_lower_nxt;
		end
	end

	always_ff @(posedge mem_clk) begin
		sdr_addr <= addr_nxt;
	end

endmodule

// ==== hdl/sdram_ctrl_top.sv ====
/*
 * SDRAM controller top level
 *   Init sequencer, slot sequencer, command generator, data path
 *   Command pin split, clock forward and tristate data bus
 */

module sdram_ctrl_top #(
	parameter logic [sdram_pkg::TIMER_W-1:0] INIT_WAIT_CYC = 16'd42960
) (
	input  logic                             mem_clk,
	input  logic                             clk21m,
	// CPU side
	input  logic                             rd,
	input  logic                             wr,
	input  logic                             refresh_req,
	input  logic [sdram_pkg::CPU_ADDR_W-1:0] address,
	input  logic [7:0]                       wdata,
	output logic                             initial_busy,
	output logic                             busy,
	output logic [7:0]                       rdata,
	output logic                             rdata_en,
	// SDRAM pins
	output logic                             sdram_clk,
	output logic                             sdram_cke,
	output logic                             sdram_cs_n,
	output logic                             sdram_ras_n,
	output logic                             sdram_cas_n,
	output logic                             sdram_we_n,
	output logic [sdram_pkg::BANK_W-1:0]     sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0]      sdram_addr,
	output logic [1:0]                       sdram_dqm,
	inout  wire  [sdram_pkg::DQ_W-1:0]       sdram_dq
);
	import sdram_pkg::*;

	init_step_t              init_step;
	logic                    ready;
	logic                    timer_zero;
	slot_state_t             slot_state;
	logic                    slot_run;
	logic                    do_refresh;
	logic                    req_valid;
	logic                    req_write;
	logic [CPU_ADDR_W-1:0]   req_addr;
	logic [7:0]              req_wdata;
	logic                    read_done;
	sdr_cmd_t                cmd;
	sdr_addr_u               sdr_addr;
	logic                    dqm_upper;
	logic                    dqm_lower;
	logic [DQ_W-1:0]         dq_out;
	logic                    dq_oe;

	sdram_init_seq #(
		.INIT_WAIT_CYC (INIT_WAIT_CYC)
	) init_seq_i (
		.mem_clk, .clk21m, .init_step, .ready, .timer_zero
	);

	sdram_slot_seq slot_seq_i (
		.mem_clk, .clk21m, .ready, .rd, .wr, .refresh_req, .address, .wdata,
		.read_done, .slot_state, .slot_run, .do_refresh, .req_valid,
		.req_write, .busy, .req_addr, .req_wdata
	);

	sdram_cmd_gen cmd_gen_i (
		.mem_clk, .clk21m, .init_step, .timer_zero, .slot_state, .slot_run,
		.do_refresh, .req_valid, .req_write, .req_addr, .cmd, .sdr_addr,
		.dqm_upper, .dqm_lower
	);

	sdram_datapath datapath_i (
		.mem_clk, .clk21m, .slot_state, .req_valid, .req_write,
		.byte_sel (req_addr[0]), .req_wdata, .dq_in (sdram_dq),
		.dq_out, .dq_oe, .rdata, .rdata_en, .read_done
	);

	// ----------------------------------------------------------------------
	// Pins
	// ----------------------------------------------------------------------
	assign initial_busy = ~ready;
	assign sdram_clk    = mem_clk;
	assign sdram_cke    = 1'b1;    // No power-down use

	assign sdram_cs_n   = cmd[3];
	assign sdram_ras_n  = cmd[2];
	assign sdram_cas_n  = cmd[1];
	assign sdram_we_n   = cmd[0];

	assign sdram_ba     = sdr_addr.access.bank;
	assign sdram_addr   = sdr_addr.access.line.row;    // Full address-line word
	assign sdram_dqm    = {dqm_upper, dqm_lower};

	assign sdram_dq     = dq_oe ? dq_out : 'z;

endmodule

// ==== hdl/sdram_datapath.sv ====
/*
 * SDRAM data path
 *   Write byte on both lanes with bus enable
 *   Read lane select, capture and data strobe
 */

module sdram_datapath (
	input  logic                       mem_clk,
	input  logic                       clk21m,
	input  sdram_pkg::slot_state_t     slot_state,
	input  logic                       req_valid,
	input  logic                       req_write,
	input  logic                       byte_sel,
	input  logic [7:0]                 req_wdata,
	input  logic [sdram_pkg::DQ_W-1:0] dq_in,
	output logic [sdram_pkg::DQ_W-1:0] dq_out,
	output logic                       dq_oe,
	output logic [7:0]                 rdata,
	output logic                       rdata_en,
	output logic                       read_done
);
	import sdram_pkg::*;

	// CAS latency 2 puts read data here
	assign read_done = req_valid & ~req_write & (slot_state == SLOT_DATA_FETCH);

	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			dq_oe    <= 1'b0;
			rdata_en <= 1'b0;
		end
		else begin
			// Bus driven only alongside the write command
			dq_oe    <= req_valid & req_write & (slot_state == SLOT_READ_OR_WRITE);
			rdata_en <= read_done;
		end
	end

	always_ff @(posedge mem_clk) begin
		if (slot_state == SLOT_READ_OR_WRITE) begin
			dq_out <= {req_wdata, req_wdata};    // DQM picks the lane
		end
		if (read_done) begin
			rdata <= byte_sel ? dq_in[DQ_W-1 -: 8] : dq_in[7:0];
		end
	end

endmodule

// ==== hdl/sdram_init_seq.sv ====
/*
 * Power-up sequencer
 *   Long first wait, precharge all, two refreshes, mode set
 *   Main countdown timer loaded on each send step
 */

module sdram_init_seq #(
	parameter logic [sdram_pkg::TIMER_W-1:0] INIT_WAIT_CYC = 16'd42960
) (
	input  logic                  mem_clk,
	input  logic                  clk21m,
	output sdram_pkg::init_step_t init_step,
	output logic                  ready,
	output logic                  timer_zero
);
	import sdram_pkg::*;

	logic [TIMER_W-1:0] timer;

	assign timer_zero = (timer == '0);

	// ----------------------------------------------------------------------
	// Step order and countdown
	// ----------------------------------------------------------------------
	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			init_step <= INIT_FIRST_WAIT;
			timer     <= INIT_WAIT_CYC;
		end
		else if (!timer_zero) begin
			timer <= timer - 1'b1;
		end
		else begin
			// Send step, the matching command leaves cmd_gen now
			case (init_step)
				INIT_FIRST_WAIT: begin
					init_step <= INIT_PRECHARGE;
					timer     <= T_RP_CYC;
				end
				INIT_PRECHARGE: begin
					init_step <= INIT_REFRESH1;
					timer     <= T_RFC_CYC;
				end
				INIT_REFRESH1: begin
					init_step <= INIT_REFRESH2;
					timer     <= T_RFC_CYC;
				end
				INIT_REFRESH2: begin
					init_step <= INIT_MODE_SET;
					timer     <= T_MRD_CYC;
				end
				INIT_MODE_SET: begin
					init_step <= INIT_READY;
				end
				default: begin
					init_step <= INIT_READY;    // Stays here until reset
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// Ready flag
	// ----------------------------------------------------------------------
	// One cycle behind the final step, held until reset
	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			ready <= 1'b0;
		end
		else if (init_step == INIT_READY) begin
			ready <= 1'b1;
		end
	end

endmodule

// ==== hdl/sdram_pkg.sv ====
/*
 * Shared definitions for the SDRAM controller
 *   SDRAM command codes, init steps and slot states
 *   Field widths and CPU byte address layout
 *   Init wait lengths and the mode register word
 *   Address-line union with mode and access views
 */

package sdram_pkg;

	localparam int BANK_W     = 2;
	localparam int ROW_W      = 13;
	localparam int COL_W      = 9;
	localparam int DQ_W       = 16;

	// CPU byte address is {bank, row, column, byte select}
	localparam int COL_LSB    = 1;
	localparam int ROW_LSB    = COL_LSB + COL_W;
	localparam int BANK_LSB   = ROW_LSB + ROW_W;
	localparam int CPU_ADDR_W = BANK_LSB + BANK_W;

	localparam int TIMER_W    = 16;

	// Waits after each init command, in mem_clk cycles
	localparam logic [TIMER_W-1:0] T_RP_CYC  = 16'd5;
	localparam logic [TIMER_W-1:0] T_RFC_CYC = 16'd15;
	localparam logic [TIMER_W-1:0] T_MRD_CYC = 16'd2;

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		CMD_MODE_SET      = 4'b0000,
		CMD_REFRESH       = 4'b0001,
		CMD_PRECHARGE_ALL = 4'b0010,
		CMD_ACTIVATE      = 4'b0011,
		CMD_WRITE         = 4'b0100,
		CMD_READ          = 4'b0101,
		CMD_NOP           = 4'b0111,
		CMD_DESELECT      = 4'b1111
	} sdr_cmd_t;

	typedef enum logic [2:0] {
		SLOT_ACTIVATE, SLOT_NOP1, SLOT_NOP2, SLOT_READ_OR_WRITE,
		SLOT_NOP3, SLOT_NOP4, SLOT_DATA_FETCH, SLOT_END
	} slot_state_t;

	// Each step is named after the command whose wait it covers
	typedef enum logic [2:0] {
		INIT_FIRST_WAIT, INIT_PRECHARGE, INIT_REFRESH1,
		INIT_REFRESH2, INIT_MODE_SET, INIT_READY
	} init_step_t;

	typedef union packed {
		struct packed {
			logic [1:0] bank;
			logic [2:0] reserved;
			logic       write_burst;      // 1 = single location write
			logic [1:0] op_mode;
			logic [2:0] cas_lat;
			logic       addr_type;        // 0 = sequential
			logic [2:0] burst_len;
		} mode;
		struct packed {
			logic [BANK_W-1:0] bank;
			union packed {
				logic [ROW_W-1:0] row;
				struct packed {
					logic [1:0]       rsvd_hi;
					logic             auto_pre;   // A10
					logic             rsvd_lo;
					logic [COL_W-1:0] col;
				} cmd;
			} line;
		} access;
	} sdr_addr_u;

	// CAS latency 2, single write, sequential, burst of one
	localparam sdr_addr_u MODE_WORD = 15'b00_000_1_00_010_0_000;

endpackage

// ==== hdl/sdram_slot_seq.sv ====
/*
 * Access slot sequencer
 *   Eight-state slot counter, free running once ready
 *   CPU request capture and busy flag
 *   Refresh request latch and per-slot decision
 */

module sdram_slot_seq (
	input  logic                                mem_clk,
	input  logic                                clk21m,
	input  logic                                ready,
	input  logic                                rd,
	input  logic                                wr,
	input  logic                                refresh_req,
	input  logic [sdram_pkg::CPU_ADDR_W-1:0]    address,
	input  logic [7:0]                          wdata,
	input  logic                                read_done,
	output sdram_pkg::slot_state_t              slot_state,
	output logic                                slot_run,
	output logic                                do_refresh,
	output logic                                req_valid,
	output logic                                req_write,
	output logic                                busy,
	output logic [sdram_pkg::CPU_ADDR_W-1:0]    req_addr,
	output logic [7:0]                          req_wdata
);
	import sdram_pkg::*;

	logic accept;
	logic slot_start;
	logic slot_done;
	logic req_pend;        // Captured, not yet given a slot
	logic refresh_pend;

	assign accept     = (rd | wr) & ~busy & ready;
	assign slot_start = ready & (~slot_run | (slot_state == SLOT_END));
	// Write is finished once its data cycle is past
	assign slot_done  = read_done |
		(req_valid & req_write & (slot_state == SLOT_DATA_FETCH));

	// ----------------------------------------------------------------------
	// Slot counter
	// ----------------------------------------------------------------------
	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			slot_run   <= 1'b0;
			slot_state <= SLOT_ACTIVATE;
		end
		else begin
			slot_run <= ready;
			if (slot_run) begin
				slot_state <= slot_state_t'(slot_state + 3'd1);    // Wraps to activate
			end
		end
	end

	// ----------------------------------------------------------------------
	// Request and refresh bookkeeping
	// ----------------------------------------------------------------------
	always_ff @(posedge mem_clk or posedge clk21m) begin
		if (clk21m) begin
			busy         <= 1'b0;
			req_pend     <= 1'b0;
			refresh_pend <= 1'b0;
			do_refresh   <= 1'b0;
			req_valid    <= 1'b0;
		end
		else begin
			if (accept) begin
				busy <= 1'b1;
			end
			else if (slot_done) begin
				busy <= 1'b0;
			end

			// Refresh wins the slot, the CPU request waits one more
			if (slot_start) begin
				do_refresh <= refresh_pend;
				req_valid  <= req_pend & ~refresh_pend;
			end

			if (accept) begin
				req_pend <= 1'b1;
			end
			else if (slot_start && !refresh_pend) begin
				req_pend <= 1'b0;
			end

			if (refresh_req) begin
				refresh_pend <= 1'b1;
			end
			else if (slot_start) begin
				refresh_pend <= 1'b0;
			end
		end
	end

	// Request payload, stable while busy
	always_ff @(posedge mem_clk) begin
		if (accept) begin
			req_addr  <= address;
			req_wdata <= wdata;
			req_write <= wr;
		end
	end

endmodule

// ==== verification/sdram_model.sv ====
/*
 * Behavioral SDRAM for the testbench
 *   Command decode, sparse word memory, CAS latency 2 reads
 *   Power-up order, mode word and open bank checks
 */

module sdram_model (
	input  logic        clk,
	input  logic        cke,
	input  logic        cs_n,
	input  logic        ras_n,
	input  logic        cas_n,
	input  logic        we_n,
	input  logic [1:0]  ba,
	input  logic [12:0] addr,
	input  logic [1:0]  dqm,
	inout  wire  [15:0] dq,
	output logic        init_done,
	output int          refresh_count,
	output int          act_refresh_count,    // Refresh count at the last activate
	output int          protocol_errors
);
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_pkg::*;

	logic [15:0] mem [logic [23:0]];
	logic [12:0] open_row [4];
	logic [3:0]  bank_open;
	int          init_phase;    // Power-up commands seen so far
	logic [3:0]  cmd;
	logic [23:0] key;
	logic [15:0] word;
	logic        rd_stage;
	logic [23:0] rd_key;
	logic        dq_drive;
	logic [15:0] dq_val;

	assign cmd = {cs_n, ras_n, cas_n, we_n};
	assign dq  = dq_drive ? dq_val : 'z;

	// Unwritten words read back a pattern of their whole address
	function automatic logic [15:0] word_at(input logic [23:0] k);
		if (mem.exists(k)) return mem[k];
		return k[15:0] ^ {k[23:16], k[23:16]};
	endfunction

	task automatic report_violation(input string what);
		protocol_errors++;
		$display("SDRAM model at %0t ns: %s", $time, what);
	endtask

	initial begin
		init_done         = 1'b0;
		refresh_count     = 0;
		act_refresh_count = 0;
		protocol_errors   = 0;
		init_phase        = 0;
		bank_open         = '0;
		rd_stage          = 1'b0;
		dq_drive          = 1'b0;
	end

	always @(posedge clk) begin
		dq_drive <= rd_stage;    // Valid for the second edge after READ
		rd_stage <= 1'b0;
		if (rd_stage) dq_val <= word_at(rd_key);
		if (cke && cs_n === 1'b0) begin
			case (cmd)
				CMD_PRECHARGE_ALL: begin
					if (init_phase == 0) init_phase = 1;
					else if (!init_done) report_violation("precharge all out of power-up order");
					if (!addr[10]) report_violation("precharge without A10 high");
					bank_open = '0;
				end
				CMD_REFRESH: begin
					if (init_phase == 1 || init_phase == 2) init_phase++;
					else if (!init_done) report_violation("refresh out of power-up order");
					if (|bank_open) report_violation("refresh while a bank is still open");
					refresh_count++;
				end
				CMD_MODE_SET: begin
					if (init_phase != 3) begin
						report_violation("mode register set out of power-up order");
					end
					else begin
						init_phase = 4;
						init_done  = 1'b1;
					end
					// CL2, single write, sequential, burst of one
					if (ba !== 2'b00 || addr[2:0] !== 3'b000 || addr[3] !== 1'b0 ||
						addr[6:4] !== 3'd2 || addr[9] !== 1'b1)
						report_violation("mode word is not CL2 single write burst of one");
				end
				CMD_ACTIVATE: begin
					if (!init_done) report_violation("activate before the power-up order ended");
					if (bank_open[ba]) report_violation("activate to a bank that is open");
					bank_open[ba]     = 1'b1;
					open_row[ba]      = addr;
					act_refresh_count = refresh_count;
				end
				CMD_READ, CMD_WRITE: begin
					if (!bank_open[ba]) report_violation("read or write to a closed bank");
					if (!addr[10]) report_violation("read or write without auto-precharge");
					key = {ba, open_row[ba], addr[8:0]};
					if (cmd == CMD_WRITE) begin
						if (&dqm) report_violation("write with both byte lanes masked");
						word = word_at(key);
						if (!dqm[0]) word[7:0] = dq[7:0];
						if (!dqm[1]) word[15:8] = dq[15:8];
						mem[key] = word;
					end
					else begin
						rd_key   <= key;
						rd_stage <= 1'b1;
					end
					bank_open[ba] = 1'b0;    // Auto-precharge
				end
				CMD_NOP: ;
				default: report_violation("unsupported command on the pins");
			endcase
		end
	end

endmodule

// ==== verification/tb_clk_gen.sv ====
/*
 * Testbench clock and reset
 *   10 ns mem_clk, reset high for the first two cycles
 */

module tb_clk_gen #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYC = 2
) (
	output logic mem_clk,
	output logic clk21m
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		mem_clk = 1'b0;
		forever #(PERIOD_NS / 2.0) mem_clk = ~mem_clk;
	end

	// Released on a falling edge, away from the DUT's sampling edge
	initial begin
		clk21m = 1'b1;
		repeat (RESET_CYC) @(posedge mem_clk);
		@(negedge mem_clk);
		clk21m = 1'b0;
	end

endmodule

// ==== verification/tb_sdram_ctrl.sv ====
/*
 * SDRAM controller testbench
 *   Init order and ready time, write/read, byte lanes
 *   Refresh priority and random traffic against a shadow memory
 *   Reference function, compare process, check task, watchdog
 */

module tb_sdram_ctrl;
	timeunit 1ns;
	timeprecision 100ps;
	import sdram_pkg::*;

	localparam int INIT_WAIT = 200;
	localparam int RAND_OPS  = 200;
	localparam int N_OPS     = RAND_OPS + 8;
	localparam int READY_CYC = INIT_WAIT + 5 + 2 * 15 + 2 + 6;    // tRP, two tRFC, tMRD
	localparam int OP_LIMIT  = 24;
	localparam int WDOG_CYC  = INIT_WAIT + 60 + N_OPS * 40;

	logic                  mem_clk;
	logic                  clk21m;
	logic                  rd;
	logic                  wr;
	logic                  refresh_req;
	logic [CPU_ADDR_W-1:0] address;
	logic [7:0]            wdata;
	logic                  initial_busy;
	logic                  busy;
	logic [7:0]            rdata;
	logic                  rdata_en;
	logic                  sdram_clk, sdram_cke, sdram_cs_n;
	logic                  sdram_ras_n, sdram_cas_n, sdram_we_n;
	logic [BANK_W-1:0]     sdram_ba;
	logic [ROW_W-1:0]      sdram_addr;
	logic [1:0]            sdram_dqm;
	wire  [DQ_W-1:0]       sdram_dq;
	logic                  model_init_done;
	int                    refresh_count, act_refresh_count, model_errors;

	logic [7:0]            shadow [logic [CPU_ADDR_W-1:0]];    // Byte per CPU address
	logic [CPU_ADDR_W-1:0] written [$];
	logic [CPU_ADDR_W-1:0] read_addr;
	logic                  read_pending;
	int                    errors, checks, reads_issued, reads_checked;

	tb_clk_gen clk_gen_i (.mem_clk, .clk21m);

	sdram_ctrl_top #(.INIT_WAIT_CYC (INIT_WAIT)) dut_i (
		.mem_clk, .clk21m, .rd, .wr, .refresh_req, .address, .wdata,
		.initial_busy, .busy, .rdata, .rdata_en, .sdram_clk, .sdram_cke,
		.sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n, .sdram_ba,
		.sdram_addr, .sdram_dqm, .sdram_dq
	);

	sdram_model model_i (
		.clk (sdram_clk), .cke (sdram_cke), .cs_n (sdram_cs_n), .ras_n (sdram_ras_n),
		.cas_n (sdram_cas_n), .we_n (sdram_we_n), .ba (sdram_ba), .addr (sdram_addr),
		.dqm (sdram_dqm), .dq (sdram_dq), .init_done (model_init_done),
		.refresh_count, .act_refresh_count, .protocol_errors (model_errors)
	);

	// Expected byte: last value written to that CPU address
	function automatic logic [7:0] expected_byte(input logic [CPU_ADDR_W-1:0] a);
		if (shadow.exists(a)) return shadow[a];
		return 8'hxx;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, actual, expected, $time);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic wait_idle();
		do @(negedge mem_clk); while (busy || initial_busy);
	endtask

	// One CPU access, waits for completion and checks its timing
	task automatic cpu_access(input logic is_write, input logic [CPU_ADDR_W-1:0] a,
			input logic [7:0] data, input logic with_refresh);
		logic done;
		int   latency;
		int   min_lat;
		wait_idle();
		@(posedge mem_clk);
		rd          <= ~is_write;
		wr          <= is_write;
		refresh_req <= with_refresh;
		address     <= a;
		wdata       <= data;
		if (is_write) begin
			shadow[a] = data;
		end
		else begin
			read_addr    = a;
			read_pending = 1'b1;
			reads_issued++;
		end
		@(posedge mem_clk);
		rd          <= 1'b0;
		wr          <= 1'b0;
		refresh_req <= 1'b0;
		min_lat = with_refresh ? 17 : 9;    // A refresh slot ahead adds eight
		latency = 0;
		done    = 1'b0;
		while (!done && latency < OP_LIMIT) begin
			@(negedge mem_clk);
			latency++;
			done = is_write ? !busy : rdata_en;
			if (latency == 1 && !busy) report_failure("busy did not rise after an accepted strobe");
			else if (!done && !busy) report_failure("busy low while a read is outstanding");
		end
		if (!done) begin
			report_failure($sformatf("access did not complete within %0d cycles", OP_LIMIT));
		end
		else begin
			if (!is_write) begin
				check_value("busy", busy, 32'd0);    // Falls with rdata_en
			end
			if (latency < min_lat || latency > min_lat + 7)
				report_failure($sformatf("access latency of %0d cycles is outside %0d to %0d",
					latency, min_lat, min_lat + 7));
		end
	endtask

	// ---------------------------------------------------------------------
	// Compare process
	// ---------------------------------------------------------------------
	always @(negedge mem_clk) begin
		if (rdata_en === 1'b1) begin
			if (read_pending) begin
				check_value("rdata", rdata, expected_byte(read_addr));
				read_pending = 1'b0;
				reads_checked++;
			end
			else begin
				report_failure("rdata_en pulsed with no read outstanding");
			end
		end
	end

	initial begin
		repeat (WDOG_CYC) @(posedge mem_clk);
		$display("Watchdog ended the run after %0d cycles without completion", WDOG_CYC);
		$display("Test failures found");
		$finish;
	end

	// ---------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------
	initial begin
		int                    ready_cyc;
		int                    r0;
		logic                  is_wr;
		logic [CPU_ADDR_W-1:0] a;
		void'($urandom(32'h77e1));
		errors        = 0;
		checks        = 0;
		reads_issued  = 0;
		reads_checked = 0;
		read_pending  = 1'b0;
		rd            = 1'b0;
		wr            = 1'b0;
		refresh_req   = 1'b0;
		address       = '0;
		wdata         = '0;

		// Power-up order and ready time
		@(negedge clk21m);
		ready_cyc = 0;
		while (initial_busy !== 1'b0 && ready_cyc < READY_CYC + 20) begin
			@(posedge mem_clk);
			ready_cyc++;
			@(negedge mem_clk);
		end
		check_value("initial_busy fall cycle", ready_cyc, READY_CYC);
		if (!model_init_done) report_failure("SDRAM model did not see the full power-up order");

		// Write then read back
		a = 25'h0A_1234;
		cpu_access(1'b1, a, 8'h3C, 1'b0);
		cpu_access(1'b0, a, 8'h00, 1'b0);

		// Both byte lanes of one word
		a = 25'h15_5550;
		cpu_access(1'b1, a, 8'hA5, 1'b0);
		cpu_access(1'b1, a | 25'd1, 8'h5A, 1'b0);
		cpu_access(1'b0, a, 8'h00, 1'b0);
		cpu_access(1'b0, a | 25'd1, 8'h00, 1'b0);

		// Refresh request ahead of a read in the same slot
		r0 = refresh_count;
		cpu_access(1'b0, 25'h0A_1234, 8'h00, 1'b1);
		if (act_refresh_count <= r0)
			report_failure("no refresh reached the SDRAM before the read's activate");

		for (int i = 0; i < RAND_OPS; i++) begin
			is_wr = (written.size() == 0) || ($urandom_range(1, 0) == 1);
			if (is_wr) begin
				a = CPU_ADDR_W'($urandom);    // Any bank, row, column and byte
				written.push_back(a);
			end
			else begin
				a = written[$urandom_range(written.size() - 1, 0)];
			end
			cpu_access(is_wr, a, 8'($urandom), $urandom_range(7, 0) == 0);
		end

		repeat (4) @(posedge mem_clk);
		check_value("reads checked", reads_checked, reads_issued);
		$display("Errors: %0d testbench, %0d SDRAM model, over %0d checks",
			errors, model_errors, checks);
		if (errors == 0 && model_errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
